/* design/rv_types_pkg.sv */
// RV32I pipeline shared types
`default_nettype none

package rv_types_pkg;

    // ====================
    // Widths and constants
    typedef logic [31:0] word_t;     // Data, instruction and address word
    typedef logic [4:0]  reg_idx_t;  // Register index

    localparam word_t RESET_PC = 32'h0000_0000;  // PC of first word after reset
    localparam word_t PC_STEP  = 32'd4;          // One word per instruction

    // ====================
    // Opcode types, built as {IR[6:5], IR[4:2]}
    typedef enum logic [4:0] {
        INSTR_OPIMM = 5'b00_100,
        INSTR_AUIPC = 5'b00_101,
        INSTR_OP    = 5'b01_100,
        INSTR_LUI   = 5'b01_101
    } opcode_type_e;

    // ALU result select
    typedef enum logic [2:0] {
        ALU_ADDER,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_COMP,
        ALU_SHIFT
    } alu_sel_e;

    // Decode sequencer
    typedef enum logic [1:0] {
        ID1,  // Controls
        ID2   // Operands
    } decode_state_e;

endpackage

`default_nettype wire

/* design/rv_fetch.sv */
// Instruction fetch buffer
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
    input  logic                clk,
    input  logic                rstz,
    // Instruction stream
    input  rv_types_pkg::word_t instr,
    input  logic                instr_vld,
    output logic                instr_rdy,
    // To decode
    output rv_types_pkg::word_t fetch_ir,
    output rv_types_pkg::word_t fetch_pc,
    output logic                fetch_vld,
    input  logic                fetch_rdy
);
    import rv_types_pkg::*;

    word_t next_pc;  // PC given to the next accepted word
    logic  accept;

    assign accept    = instr_vld & instr_rdy;
    assign instr_rdy = ~fetch_vld | fetch_rdy;  // Empty, or draining this cycle

    // ====================
    // Buffer control
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            fetch_vld <= 1'b0;
            next_pc   <= RESET_PC;
        end else begin
            if (accept) begin
                fetch_vld <= 1'b1;
                next_pc   <= next_pc + PC_STEP;
            end else if (fetch_rdy) begin
                fetch_vld <= 1'b0;  // Drained, nothing new
            end
        end
    end

    // Word and its PC
    always_ff @(posedge clk) begin
        if (accept) begin
            fetch_ir <= instr;
            fetch_pc <= next_pc;
        end
    end

    // ====================
    // Checks
    a_fetch_hold: assert property (@(posedge clk) disable iff (!rstz)
        fetch_vld && !fetch_rdy |=> fetch_vld && $stable(fetch_ir) && $stable(fetch_pc));

endmodule

`default_nettype wire

/* design/rv_decode.sv */
// RV32I decode stage
// Register file, immediates, ALU controls, scoreboard
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic                   clk,
    input  logic                   rstz,
    // From fetch
    input  rv_types_pkg::word_t    fetch_ir,
    input  rv_types_pkg::word_t    fetch_pc,
    input  logic                   fetch_vld,
    output logic                   fetch_rdy,
    // To execute
    output rv_types_pkg::word_t    op1,
    output rv_types_pkg::word_t    op2,
    output logic                   alu_neg,
    output logic                   alu_rev,
    output logic                   alu_cin,
    output logic                   alu_uns,
    output logic                   alu_gte,
    output rv_types_pkg::alu_sel_e alu_sel,
    output rv_types_pkg::reg_idx_t rd,
    output logic                   rd_write,
    output logic                   illegal,
    output logic                   decode_vld,
    input  logic                   decode_rdy,
    // Write-back
    input  logic                   regwr_en,
    input  rv_types_pkg::reg_idx_t regwr_sel,
    input  rv_types_pkg::word_t    regwr_data
);
    import rv_types_pkg::*;

    // Instruction fields
    opcode_type_e opcode_type;
    reg_idx_t     rs1_idx;
    reg_idx_t     rs2_idx;
    reg_idx_t     rd_idx;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    logic         f7_zero;
    logic         f7_alt;   // 0100000, SUB and SRA(I)
    logic         is_op;

    // Register file, one copy per read port
    word_t rf_a [32];
    word_t rf_b [32];
    word_t rs1_data;
    word_t rs2_data;
    logic  rs1_en;
    logic  rs2_en;
    logic  rs1_read;   // Held from ID1 into ID2
    logic  rs2_read;

    // Immediate segments
    logic [31:12] tir;  // Only the upper bits feed I and U formats
    logic         format_i;
    logic         format_u;
    logic         sign;
    logic         imm_a;  // [0]
    logic [3:0]   imm_b;  // [4:1]
    logic [5:0]   imm_c;  // [10:5]
    logic         imm_d;  // [11]
    logic [7:0]   imm_e;  // [19:12]
    logic [11:0]  imm_f;  // [31:20]
    word_t        immediate;

    // Decoded controls
    logic     dec_neg;
    logic     dec_rev;
    logic     dec_cin;
    logic     dec_uns;
    alu_sel_e dec_sel;
    logic     ill_opcode;
    logic     ill_format;
    logic     ill_funct;
    logic     ill_type;
    logic     dec_illegal;
    logic     dec_write;

    // Sequencer and scoreboard
    decode_state_e state;
    decode_state_e next_state;
    logic [31:0]   pending;  // One bit per register with a write in flight
    logic [31:0]   set_mask;
    logic [31:0]   clr_mask;
    logic          hazard;
    logic          accept;

    // ====================
    // Field decode
    assign opcode_type = opcode_type_e'({fetch_ir[6:5], fetch_ir[4:2]});
    assign rs1_idx     = fetch_ir[19:15];
    assign rs2_idx     = fetch_ir[24:20];
    assign rd_idx      = fetch_ir[11:7];
    assign funct3      = fetch_ir[14:12];
    assign funct7      = fetch_ir[31:25];
    assign f7_zero     = funct7 == 7'd0;
    assign f7_alt      = funct7 == 7'd32;
    assign is_op       = opcode_type == INSTR_OP;

    // All-zero or all-one opcode, or not a 32-bit encoding
    assign ill_opcode = (fetch_ir[6:0] == 7'h00) || (fetch_ir[6:0] == 7'h7f);
    assign ill_format = fetch_ir[1:0] != 2'b11;

    // ====================
    // Register file
    assign rs1_en = (opcode_type == INSTR_OPIMM) || is_op;
    assign rs2_en = is_op;

    always_ff @(posedge clk) begin
        rs1_data <= (rs1_en && rs1_idx != '0) ? rf_a[rs1_idx] : '0;  // x0 reads zero
        rs2_data <= (rs2_en && rs2_idx != '0) ? rf_b[rs2_idx] : '0;
    end

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            rf_a <= '{default: '0};
            rf_b <= '{default: '0};
        end else if (regwr_en) begin
            rf_a[regwr_sel] <= regwr_data;
            rf_b[regwr_sel] <= regwr_data;
        end
    end

    // ====================
    // Immediate
    always_ff @(posedge clk) begin
        format_i <= opcode_type == INSTR_OPIMM;
        format_u <= (opcode_type == INSTR_LUI) || (opcode_type == INSTR_AUIPC);
        tir      <= fetch_ir[31:12];
    end

    assign sign = tir[31];

    always_comb begin
        imm_a = format_i ? tir[20] : 1'b0;
        imm_b = format_u ? 4'h0 : tir[24:21];
        imm_c = format_u ? 6'h00 : tir[30:25];
        imm_d = format_u ? 1'b0 : sign;
        imm_e = format_u ? tir[19:12] : {8{sign}};
        imm_f = format_u ? tir[31:20] : {12{sign}};
    end

    assign immediate = {imm_f, imm_e, imm_d, imm_c, imm_b, imm_a};

    // ====================
    // ALU controls
    always_comb begin
        dec_neg   = 1'b0;       // Default is a plain add
        dec_rev   = 1'b0;
        dec_cin   = 1'b0;
        dec_uns   = 1'b0;
        dec_sel   = ALU_ADDER;
        ill_funct = 1'b0;
        ill_type  = 1'b0;
        case (opcode_type)
            INSTR_OPIMM, INSTR_OP: begin
                case (funct3)
                    3'b000: begin  // ADDI, ADD, SUB
                        if (is_op) begin
                            dec_neg   = f7_alt;
                            dec_cin   = f7_alt;
                            ill_funct = !(f7_zero || f7_alt);
                        end
                    end
                    3'b001: begin  // SLLI, SLL
                        dec_rev   = 1'b1;
                        dec_sel   = ALU_SHIFT;
                        ill_funct = !f7_zero;
                    end
                    3'b010, 3'b011: begin  // SLT(I), SLT(I)U
                        dec_neg   = 1'b1;
                        dec_cin   = 1'b1;
                        dec_uns   = funct3[0];
                        dec_sel   = ALU_COMP;
                        ill_funct = is_op && !f7_zero;
                    end
                    3'b100: begin
                        dec_sel   = ALU_XOR;
                        ill_funct = is_op && !f7_zero;
                    end
                    3'b101: begin  // SRL(I), SRA(I)
                        dec_cin   = f7_alt;   // Arithmetic fill
                        dec_sel   = ALU_SHIFT;
                        ill_funct = !(f7_zero || f7_alt);
                    end
                    3'b110: begin
                        dec_sel   = ALU_OR;
                        ill_funct = is_op && !f7_zero;
                    end
                    default: begin  // 3'b111
                        dec_sel   = ALU_AND;
                        ill_funct = is_op && !f7_zero;
                    end
                endcase
            end
            INSTR_LUI, INSTR_AUIPC: dec_sel = ALU_ADDER;  // op1 plus upper immediate
            default:                ill_type = 1'b1;      // Outside the supported set
        endcase
    end

    assign dec_illegal = ill_opcode | ill_format | ill_funct | ill_type;
    assign dec_write   = (rd_idx != '0) && !dec_illegal;

    // ====================
    // Scoreboard
    // A pending rd also stalls, so only one write per register is in flight
    assign hazard = (rs1_en && pending[rs1_idx])
                 || (rs2_en && pending[rs2_idx])
                 || (dec_write && pending[rd_idx]);

    assign accept   = fetch_vld & fetch_rdy;
    assign set_mask = {31'b0, accept & dec_write} << rd_idx;
    assign clr_mask = {31'b0, regwr_en} << regwr_sel;

    assign fetch_rdy = (state == ID1) && (!decode_vld || decode_rdy) && !hazard;

    // ====================
    // Sequencer
    always_comb begin
        next_state = state;
        case (state)
            ID1:     if (accept) next_state = ID2;
            ID2:     next_state = ID1;
            default: next_state = ID1;
        endcase
    end

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state      <= ID1;
            decode_vld <= 1'b0;
            pending    <= '0;
        end else begin
            state <= next_state;
            if (state == ID2) begin
                decode_vld <= 1'b1;  // Operands final
            end else if (decode_vld && decode_rdy) begin
                decode_vld <= 1'b0;
            end
            pending <= (pending & ~clr_mask) | set_mask;
        end
    end

    // Controls load in ID1, operands in ID2
    always_ff @(posedge clk) begin
        if (accept) begin
            alu_neg  <= dec_neg;
            alu_rev  <= dec_rev;
            alu_cin  <= dec_cin;
            alu_uns  <= dec_uns;
            alu_gte  <= 1'b0;    // Branch compares only
            alu_sel  <= dec_sel;
            illegal  <= dec_illegal;
            rd_write <= dec_write;
            rd       <= dec_write ? rd_idx : '0;
            rs1_read <= rs1_en;
            rs2_read <= rs2_en;
            op1      <= (opcode_type == INSTR_LUI) ? '0 : fetch_pc;  // PC for AUIPC
        end else if (state == ID2) begin
            if (rs1_read) begin
                op1 <= rs1_data;
            end
            op2 <= rs2_read ? rs2_data : immediate;
        end
    end

    // ====================
    // Checks
    a_decode_hold: assert property (@(posedge clk) disable iff (!rstz)
        decode_vld && !decode_rdy |=> decode_vld && $stable(op1) && $stable(op2));

    // Write-back from execute only for registers marked here
    a_wb_pending: assert property (@(posedge clk) disable iff (!rstz)
        regwr_en |-> pending[regwr_sel]);

endmodule

`default_nettype wire

/* design/rv_execute.sv */
// RV32I execute stage
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic                   clk,
    input  logic                   rstz,
    // From decode
    input  rv_types_pkg::word_t    op1,
    input  rv_types_pkg::word_t    op2,
    input  logic                   alu_neg,
    input  logic                   alu_rev,
    input  logic                   alu_cin,
    input  logic                   alu_uns,
    input  logic                   alu_gte,
    input  rv_types_pkg::alu_sel_e alu_sel,
    input  rv_types_pkg::reg_idx_t rd,
    input  logic                   rd_write,
    input  logic                   illegal,
    input  logic                   decode_vld,
    output logic                   decode_rdy,
    // Result
    output rv_types_pkg::word_t    result_data,
    output rv_types_pkg::reg_idx_t result_rd,
    output logic                   result_write,
    output logic                   result_illegal,
    output logic                   result_vld,
    input  logic                   result_rdy,
    // Write-back to decode
    output logic                   regwr_en,
    output rv_types_pkg::reg_idx_t regwr_sel,
    output rv_types_pkg::word_t    regwr_data
);
    import rv_types_pkg::*;

    word_t              op2_neg;
    word_t              sum;
    logic               cout;
    logic               lt;
    word_t              shift_in;
    logic signed [32:0] shift_ext;  // Fill bit on top
    word_t              shift_out;
    word_t              alu_out;
    logic               accept;

    function automatic word_t bit_rev(input word_t w);
        word_t r;
        for (int i = 0; i < 32; i++) begin
            r[i] = w[31 - i];
        end
        return r;
    endfunction

    // ====================
    // Adder and compare
    assign op2_neg     = alu_neg ? ~op2 : op2;  // With cin, op1 - op2
    assign {cout, sum} = {1'b0, op1} + {1'b0, op2_neg} + {32'b0, alu_cin};

    // Signs differ, op1 sign decides
    assign lt = alu_uns ? ~cout : ((op1[31] ^ op2[31]) ? op1[31] : sum[31]);

    // Shifter, left shift by reversing around a right shift
    assign shift_in  = alu_rev ? bit_rev(op1) : op1;
    assign shift_ext = $signed({alu_cin & shift_in[31], shift_in}) >>> op2[4:0];
    assign shift_out = alu_rev ? bit_rev(shift_ext[31:0]) : shift_ext[31:0];

    always_comb begin
        case (alu_sel)
            ALU_ADDER: alu_out = sum;
            ALU_AND:   alu_out = op1 & op2;
            ALU_OR:    alu_out = op1 | op2;
            ALU_XOR:   alu_out = op1 ^ op2;
            ALU_COMP:  alu_out = {31'b0, lt ^ alu_gte};  // gte flips the test
            ALU_SHIFT: alu_out = shift_out;
            default:   alu_out = sum;
        endcase
    end

    // ====================
    // Result register
    assign accept     = decode_vld & decode_rdy;
    assign decode_rdy = ~result_vld | result_rdy;  // Empty or draining

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            result_vld <= 1'b0;
        end else if (accept) begin
            result_vld <= 1'b1;
        end else if (result_rdy) begin
            result_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result_data    <= illegal ? '0 : alu_out;
            result_rd      <= rd;
            result_write   <= rd_write;
            result_illegal <= illegal;
        end
    end

    // Write-back on the transfer out
    assign regwr_en   = result_vld & result_rdy & result_write;
    assign regwr_sel  = result_rd;
    assign regwr_data = result_data;

    // ====================
    // Checks
    a_result_hold: assert property (@(posedge clk) disable iff (!rstz)
        result_vld && !result_rdy |=> result_vld && $stable(result_data)
            && $stable(result_rd) && $stable(result_write) && $stable(result_illegal));

    // Decode must have dropped the write of an illegal instruction
    a_illegal_quiet: assert property (@(posedge clk) disable iff (!rstz)
        result_vld && result_illegal |-> !result_write);

endmodule

`default_nettype wire

/* design/rv_core.sv */
// RV32I integer pipeline top
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                   clk,
    input  logic                   rstz,
    // Instruction stream
    input  rv_types_pkg::word_t    instr,
    input  logic                   instr_vld,
    output logic                   instr_rdy,
    // Results
    output rv_types_pkg::word_t    result_data,
    output rv_types_pkg::reg_idx_t result_rd,
    output logic                   result_write,
    output logic                   result_illegal,
    output logic                   result_vld,
    input  logic                   result_rdy
);
    import rv_types_pkg::*;

    // Fetch to decode
    word_t    fetch_ir;
    word_t    fetch_pc;
    logic     fetch_vld;
    logic     fetch_rdy;

    // Decode to execute
    word_t    op1;
    word_t    op2;
    logic     alu_neg;
    logic     alu_rev;
    logic     alu_cin;
    logic     alu_uns;
    logic     alu_gte;
    alu_sel_e alu_sel;
    reg_idx_t rd;
    logic     rd_write;
    logic     illegal;
    logic     decode_vld;
    logic     decode_rdy;

    // Write-back
    logic     regwr_en;
    reg_idx_t regwr_sel;
    word_t    regwr_data;

    // Port names match the nets above
    rv_fetch   u_fetch   (.*);
    rv_decode  u_decode  (.*);
    rv_execute u_execute (.*);

endmodule

`default_nettype wire

/* testbench/tb_rv_core.sv */
// RV32I pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_types_pkg::*;

    localparam int    SEED           = 60392;
    localparam int    RESET_CYCLES   = 16;
    localparam int    TIMEOUT_CYCLES = 400;   // Idle cycles allowed between results
    localparam int    DRAIN_CYCLES   = 12;
    localparam int    MAX_LINES      = 64;
    localparam string GOLDEN_FILE    = "testbench/rv_core_golden.txt";

    logic     clk;
    logic     rstz;
    word_t    instr;
    logic     instr_vld;
    logic     instr_rdy;
    word_t    result_data;
    reg_idx_t result_rd;
    logic     result_write;
    logic     result_illegal;
    logic     result_vld;
    logic     result_rdy;

    // Golden table, one entry per instruction
    word_t    gold_instr   [MAX_LINES];
    reg_idx_t gold_rd      [MAX_LINES];
    logic     gold_write   [MAX_LINES];
    word_t    gold_data    [MAX_LINES];
    logic     gold_illegal [MAX_LINES];
    int       num_lines;
    int       pend_q [$];  // Golden indices of accepted instructions in program order

    rv_core u_rv_core (
        .clk            (clk),
        .rstz           (rstz),
        .instr          (instr),
        .instr_vld      (instr_vld),
        .instr_rdy      (instr_rdy),
        .result_data    (result_data),
        .result_rd      (result_rd),
        .result_write   (result_write),
        .result_illegal (result_illegal),
        .result_vld     (result_vld),
        .result_rdy     (result_rdy)
    );

    always #20 clk = ~clk;  // 40 ns period

    // ====================
    // Compare and abort
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input string field, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, field, got, exp);
            $display("Simulation failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_reg(input string field, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, field, got, exp);
            $display("Simulation failed");
            $fatal(1, "register index mismatch");
        end
    endtask

    task automatic check_flag(input string field, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, field, got, exp);
            $display("Simulation failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // ====================
    // Golden file reader
    task automatic load_golden();
        int       fd;
        int       code;
        string    line;
        word_t    w;
        reg_idx_t r;
        logic     fw;
        word_t    d;
        logic     fi;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            stop_with_failure("Cannot open the golden file");
        end
        num_lines = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 1 && line.substr(0, 0) != "#") begin  // Skip blanks and column notes
                if ($sscanf(line, "%h %d %b %h %b", w, r, fw, d, fi) != 5) begin
                    stop_with_failure("Malformed line in the golden file");
                end
                if (num_lines == MAX_LINES) begin
                    stop_with_failure("Golden file has too many lines");
                end
                gold_instr[num_lines]   = w;
                gold_rd[num_lines]      = r;
                gold_write[num_lines]   = fw;
                gold_data[num_lines]    = d;
                gold_illegal[num_lines] = fi;
                num_lines++;
            end
        end
        $fclose(fd);
    endtask

    // ====================
    // Stimulus and checking
    initial begin
        int   idx;      // Next golden line to present
        int   checked;  // Results compared so far
        int   idle;
        int   exp_idx;
        logic accepted;
        clk        = 1'b0;
        rstz       = 1'b0;
        instr      = '0;
        instr_vld  = 1'b0;
        result_rdy = 1'b0;
        void'($urandom(SEED));
        load_golden();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstz = 1'b1;
        #1;
        check_flag("instr_rdy after reset", instr_rdy, 1'b1);
        check_flag("result_vld after reset", result_vld, 1'b0);

        idx      = 0;
        checked  = 0;
        idle     = 0;
        accepted = 1'b0;
        while (checked < num_lines) begin
            @(negedge clk);
            if (accepted) begin  // Taken at the last rising edge
                pend_q.push_back(idx);
                idx++;
                instr_vld = 1'b0;
            end
            // Random idle gaps on the input
            if (!instr_vld && idx < num_lines && $urandom_range(0, 3) != 0) begin
                instr     = gold_instr[idx];
                instr_vld = 1'b1;
            end
            result_rdy = ($urandom_range(0, 3) != 0);  // Random back-pressure
            #1;                                         // Let ready paths settle
            accepted = instr_vld && instr_rdy;
            if (result_vld && result_rdy) begin
                if (pend_q.size() == 0) begin
                    stop_with_failure("Result came out with no instruction in flight");
                end
                exp_idx = pend_q.pop_front();
                check_word("result_data", result_data, gold_data[exp_idx]);
                check_reg("result_rd", result_rd, gold_rd[exp_idx]);
                check_flag("result_write", result_write, gold_write[exp_idx]);
                check_flag("result_illegal", result_illegal, gold_illegal[exp_idx]);
                checked++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT_CYCLES) begin
                    stop_with_failure("No result within timeout");
                end
            end
        end

        // Nothing may follow the last result
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            instr_vld  = 1'b0;
            result_rdy = 1'b1;
            #1;
            if (result_vld) begin
                stop_with_failure("Extra result after the last golden line");
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/rv_core_golden.txt */
# instr(hex) rd(dec) write(bin) result(hex) illegal(bin), text after the fifth column is a note
# PC of line n is 4*n, rd and write are 0 for x0 and illegal words
123450B7 1 1 12345000 0 lui x1,0x12345
00001117 2 1 00001004 0 auipc x2,0x1
FFB00193 3 1 FFFFFFFB 0 addi x3,x0,-5
06418213 4 1 0000005F 0 addi x4,x3,100
FFC1A293 5 1 00000001 0 slti x5,x3,-4
FFC1B313 6 1 00000001 0 sltiu x6,x3,-4
0011B393 7 1 00000000 0 sltiu x7,x3,1
0000A413 8 1 00000000 0 slti x8,x1,0
7FF0C493 9 1 123457FF 0 xori x9,x1,0x7ff
0F026513 10 1 000000FF 0 ori x10,x4,0xf0
F0017593 11 1 00001000 0 andi x11,x2,-256
00421613 12 1 000005F0 0 slli x12,x4,4
0081D693 13 1 00FFFFFF 0 srli x13,x3,8
4081D713 14 1 FFFFFFFF 0 srai x14,x3,8
00700793 15 1 00000007 0 addi x15,x0,7
00378833 16 1 00000002 0 add x16,x15,x3
40F808B3 17 1 FFFFFFFB 0 sub x17,x16,x15
01179933 18 1 38000000 0 sll x18,x15,x17
0108A9B3 19 1 00000001 0 slt x19,x17,x16
0108BA33 20 1 00000000 0 sltu x20,x17,x16
01194AB3 21 1 C7FFFFFB 0 xor x21,x18,x17
00FADB33 22 1 018FFFFF 0 srl x22,x21,x15
40FADBB3 23 1 FF8FFFFF 0 sra x23,x21,x15
0107EC33 24 1 00000007 0 or x24,x15,x16
00CB7CB3 25 1 000005F0 0 and x25,x22,x12
00108013 0 0 12345001 0 addi x0,x1,1
00F00D33 26 1 00000007 0 add x26,x0,x15
00000000 0 0 00000000 1 all-zero word
00100490 0 0 00000000 1 addi x9 with low bits 00
02208533 0 0 00000000 1 add x10 with funct7 0000001
00002583 0 0 00000000 1 lw x11,0(x0)
00A48DB3 27 1 123458FE 0 add x27,x9,x10
0005EE33 28 1 00001000 0 or x28,x11,x0
FFFFFE97 29 1 FFFFF084 0 auipc x29,0xfffff

/* list.f */
design/rv_types_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_core.sv
testbench/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --top-module tb_rv_core \
    -f list.f -o tb_rv_core > build.log 2>&1 \
    && ./obj_dir/tb_rv_core > "$LOG" 2>&1 \
    || echo "Build or simulation stopped with an error"

grep -qx "Simulation passed" "$LOG" && echo "PASS" && exit 0 \
    || { echo "FAIL, see $LOG and build.log"; exit 1; }
